//--- build.f
hw/axis_pkg.sv
hw/axis_upsizer.sv
hw/axis_downsizer.sv
hw/axis_width_converter.sv
sim/axis_width_converter_assert.sv
sim/axis_width_converter_checker.sv
sim/axis_width_converter_tb.sv

//--- hw/axis_downsizer.sv
//##########################################################
// splits one wide stream word into down narrow beats, lowest
// bits first; last goes out on the final beat of a last word
//##########################################################

`timescale 1ns/10ps

module axis_downsizer
  import axis_pkg::*;
#(
  parameter int word_width = out_width,
  parameter int down = comb_down
) (
  input  logic                       clk,
  input  logic                       reset,
  // wide input stream
  input  logic [word_width*down-1:0] mid_data,
  input  logic                       mid_valid,
  input  logic                       mid_last,
  // narrow output side handshake
  input  logic                       out_ready,
  output logic                       mid_ready,
  // narrow output stream
  output logic [word_width-1:0]      out_data,
  output logic                       out_valid,
  output logic                       out_last
);

  // the word being drained, slice 0 goes out first
  logic [down-1:0][word_width-1:0] hold_word;

  // index of the slice on the output
  logic [$clog2(down+1)-1:0] beat;

  logic word_last;
  logic full;

  logic out_fire;
  logic final_beat;
  logic mid_fire;

  assign out_valid = full;
  assign out_data = hold_word[beat];

  // only the closing slice of a packet's final word carries last
  assign out_last = full && word_last && (beat == down - 1);

  assign out_fire = full && out_ready;
  assign final_beat = out_fire && (beat == down - 1);

  // take a new word when empty, or as the last slice leaves
  // so that a steady stream has no gap between words
  assign mid_ready = !full || final_beat;
  assign mid_fire = mid_valid && mid_ready;

  // control state
  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
      beat <= '0;
      word_last <= 1'b0;
    end else begin
      if (mid_fire) begin
        full <= 1'b1;
        beat <= '0;
        word_last <= mid_last;
      end else if (final_beat) begin
        full <= 1'b0;
        beat <= '0;
        word_last <= 1'b0;
      end else if (out_fire) begin
        beat <= beat + 1'b1;
      end
    end
  end

  // payload register, loaded once per wide word
  always_ff @(posedge clk) begin
    if (mid_fire) begin
      hold_word <= mid_data;
    end
  end

endmodule

//--- hw/axis_pkg.sv
//##########################################################
// stream widths and packing factors for the 24-bit to 32-bit
// width converter, imported by the RTL and the checker
//##########################################################

package axis_pkg;

  // greatest common divisor, evaluated at elaboration
  function automatic int gcd(input int a, input int b);
    int x;
    int y;
    int t;
    x = a;
    y = b;
    while (y != 0) begin
      t = x % y;
      x = y;
      y = t;
    end
    return x;
  endfunction

  // narrow input and output beats
  localparam int in_width = 24;
  localparam int out_width = 32;

  // common subword, 8 bits for 24 and 32
  localparam int sub_width = gcd(in_width, out_width);

  // 4 input beats fill the wide word, 3 output beats drain it
  localparam int comb_up = out_width / sub_width;
  localparam int comb_down = in_width / sub_width;
  localparam int mid_width = in_width * comb_up;

endpackage

//--- hw/axis_upsizer.sv
//##########################################################
// packs up narrow stream beats into one wide word, first beat
// in the low bits; a last beat flushes a zero-padded word
//##########################################################

`timescale 1ns/10ps

module axis_upsizer
  import axis_pkg::*;
#(
  parameter int word_width = in_width,
  parameter int up = comb_up
) (
  input  logic                     clk,
  input  logic                     reset,
  // narrow input stream
  input  logic [word_width-1:0]    in_data,
  input  logic                     in_valid,
  input  logic                     in_last,
  // wide output side handshake
  input  logic                     mid_ready,
  output logic                     in_ready,
  // wide output stream
  output logic [word_width*up-1:0] mid_data,
  output logic                     mid_valid,
  output logic                     mid_last
);

  // accumulator slots, slot 0 holds the oldest beat
  logic [up-1:0][word_width-1:0] acc_data;

  // accumulator contents with the current beat inserted and the tail zeroed
  logic [up-1:0][word_width-1:0] fill_word;

  // next free slot in the accumulator
  logic [$clog2(up+1)-1:0] slot;

  // accumulator holds a finished word that waits for the output register
  logic acc_full;
  logic acc_last;

  logic in_fire;
  logic out_free;
  logic word_done;
  logic direct_load;
  logic acc_move;

  // the output register can take a word when empty or when it drains this cycle
  assign out_free = !mid_valid || mid_ready;

  // stall only when a finished word is parked and the output is still busy
  assign in_ready = !acc_full || out_free;

  assign in_fire = in_valid && in_ready;

  // this beat closes the word, either by count or by packet end
  assign word_done = in_fire && ((slot == up - 1) || in_last);

  // a finished word skips the accumulator when nothing is ahead of it
  assign direct_load = word_done && out_free && !acc_full;

  // a parked word moves into the output register
  assign acc_move = acc_full && out_free;

  // slots below the count keep their beats, slots above are padding
  always_comb begin
    for (int i = 0; i < up; i++) begin
      if (i < slot) begin
        fill_word[i] = acc_data[i];
      end else if (i == slot) begin
        fill_word[i] = in_data;
      end else begin
        fill_word[i] = '0;
      end
    end
  end

  // control state
  always_ff @(posedge clk) begin
    if (reset) begin
      slot <= '0;
      acc_full <= 1'b0;
      acc_last <= 1'b0;
      mid_valid <= 1'b0;
      mid_last <= 1'b0;
    end else begin
      if (acc_move) begin
        acc_full <= 1'b0;
      end

      if (in_fire) begin
        if (word_done) begin
          slot <= '0;
          // output is taken, so the finished word parks in the accumulator
          if (!direct_load) begin
            acc_full <= 1'b1;
            acc_last <= in_last;
          end
        end else begin
          slot <= slot + 1'b1;
        end
      end

      if (out_free) begin
        if (acc_full) begin
          mid_valid <= 1'b1;
          mid_last <= acc_last;
        end else if (direct_load) begin
          mid_valid <= 1'b1;
          mid_last <= in_last;
        end else begin
          mid_valid <= 1'b0;
          mid_last <= 1'b0;
        end
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (in_fire) begin
      if (word_done) begin
        if (!direct_load) begin
          acc_data <= fill_word;
        end
      end else begin
        acc_data[slot] <= in_data;
      end
    end

    // a parked word always leaves before a newer one
    if (out_free) begin
      if (acc_full) begin
        mid_data <= acc_data;
      end else if (direct_load) begin
        mid_data <= fill_word;
      end
    end
  end

endmodule

//--- hw/axis_width_converter.sv
//##########################################################
// top level of the 24-bit to 32-bit stream width converter;
// an upsizer builds 96-bit words and a downsizer cuts them
//##########################################################

`timescale 1ns/10ps

module axis_width_converter
  import axis_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  // 24-bit input stream
  input  logic [in_width-1:0]  in_data,
  input  logic                 in_valid,
  input  logic                 in_last,
  // 32-bit output side handshake
  input  logic                 out_ready,
  output logic                 in_ready,
  // 32-bit output stream
  output logic [out_width-1:0] out_data,
  output logic                 out_valid,
  output logic                 out_last
);

  // wide stream between the two stages
  logic [mid_width-1:0] mid_data;
  logic                 mid_valid;
  logic                 mid_last;
  logic                 mid_ready;

  // four 24-bit beats per 96-bit word
  axis_upsizer #(
    .word_width(in_width),
    .up(comb_up)
  ) upsizer_i (
    .clk(clk),
    .reset(reset),
    .in_data(in_data),
    .in_valid(in_valid),
    .in_last(in_last),
    .mid_ready(mid_ready),
    .in_ready(in_ready),
    .mid_data(mid_data),
    .mid_valid(mid_valid),
    .mid_last(mid_last)
  );

  // three 32-bit beats per 96-bit word
  axis_downsizer #(
    .word_width(out_width),
    .down(comb_down)
  ) downsizer_i (
    .clk(clk),
    .reset(reset),
    .mid_data(mid_data),
    .mid_valid(mid_valid),
    .mid_last(mid_last),
    .out_ready(out_ready),
    .mid_ready(mid_ready),
    .out_data(out_data),
    .out_valid(out_valid),
    .out_last(out_last)
  );

endmodule

//--- sim/axis_width_converter_assert.sv
//##########################################################
// handshake checks on the converter output stream, bound into
// every axis_width_converter instance
//##########################################################

`timescale 1ns/10ps

module axis_width_converter_assert
  import axis_pkg::*;
(
  input logic                 clk,
  input logic                 reset,
  input logic [out_width-1:0] out_data,
  input logic                 out_valid,
  input logic                 out_ready,
  input logic                 out_last
);

  // failed assertions so far
  int failures = 0;

  // a stalled beat stays put until the receiver takes it
  property stall_holds_beat;
    @(posedge clk) disable iff (reset)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last));
  endproperty

  // output stream starts out empty
  property empty_after_reset;
    @(posedge clk) reset |=> !out_valid;
  endproperty

  stall_check: assert property (stall_holds_beat)
    else begin
      $error("output beat changed while out_ready was low");
      failures++;
    end

  reset_check: assert property (empty_after_reset)
    else begin
      $error("out_valid was high in the cycle after reset");
      failures++;
    end

endmodule

bind axis_width_converter axis_width_converter_assert assert_i (
  .clk(clk),
  .reset(reset),
  .out_data(out_data),
  .out_valid(out_valid),
  .out_ready(out_ready),
  .out_last(out_last)
);

//--- sim/axis_width_converter_checker.sv
//##########################################################
// scoreboard for the width converter: records input packets,
// builds the expected 32-bit beats and compares the output
//##########################################################

`timescale 1ns/10ps

module axis_width_converter_checker
  import axis_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [in_width-1:0]  in_data,
  input  logic                 in_valid,
  input  logic                 in_ready,
  input  logic                 in_last,
  input  logic [out_width-1:0] out_data,
  input  logic                 out_valid,
  input  logic                 out_ready,
  input  logic                 out_last,
  output int                   error_count,
  output int                   packet_count,
  output int                   pending_beats
);

  // input beats of the packet in progress
  logic [in_width-1:0]  packet_beats[$];

  // expected and observed output beats, matched in order
  logic [out_width-1:0] exp_data[$];
  logic                 exp_last[$];
  logic [out_width-1:0] got_data[$];
  logic                 got_last[$];

  int errors;
  int packets;

  // reference model: byte stream of the packet, zero padded to whole wide words
  function automatic void expect_packet(input logic [in_width-1:0] beats[$]);
    logic [sub_width-1:0] bytes[$];
    logic [out_width-1:0] beat;
    int in_bytes;
    int out_bytes;
    int word_bytes;
    in_bytes = in_width / sub_width;
    out_bytes = out_width / sub_width;
    word_bytes = mid_width / sub_width;
    foreach (beats[i]) begin
      for (int b = 0; b < in_bytes; b++) begin
        bytes.push_back(beats[i][b*sub_width +: sub_width]);
      end
    end
    while (bytes.size() % word_bytes != 0) begin
      bytes.push_back('0);
    end
    // lowest byte of each output beat is the earliest one
    for (int i = 0; i < bytes.size(); i += out_bytes) begin
      beat = '0;
      for (int b = 0; b < out_bytes; b++) begin
        beat[b*sub_width +: sub_width] = bytes[i + b];
      end
      exp_data.push_back(beat);
      exp_last.push_back(i + out_bytes == bytes.size());
    end
  endfunction

  function automatic void compare_beat(input logic [out_width-1:0] want_data,
                                       input logic want_last,
                                       input logic [out_width-1:0] seen_data,
                                       input logic seen_last);
    if (seen_data !== want_data) begin
      $display("Mismatch on out_data in packet %0d: expected %h, got %h",
               packets, want_data, seen_data);
      errors++;
    end
    if (seen_last !== want_last) begin
      $display("Mismatch on out_last in packet %0d: expected %h, got %h",
               packets, want_last, seen_last);
      errors++;
    end
    if (want_last) begin
      packets++;
    end
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      packet_beats.delete();
      exp_data.delete();
      exp_last.delete();
      got_data.delete();
      got_last.delete();
      errors = 0;
      packets = 0;
    end else begin
      if (in_valid && in_ready) begin
        packet_beats.push_back(in_data);
        if (in_last) begin
          expect_packet(packet_beats);
          packet_beats.delete();
        end
      end
      if (out_valid && out_ready) begin
        got_data.push_back(out_data);
        got_last.push_back(out_last);
      end
      // early words of a long packet leave before its last input beat
      while (exp_data.size() > 0 && got_data.size() > 0) begin
        compare_beat(exp_data.pop_front(), exp_last.pop_front(),
                     got_data.pop_front(), got_last.pop_front());
      end
    end
    error_count <= errors;
    packet_count <= packets;
    pending_beats <= exp_data.size() + got_data.size() + packet_beats.size();
  end

endmodule

//--- sim/axis_width_converter_tb.sv
//##########################################################
// testbench for the 24-bit to 32-bit stream width converter;
// runs five stimulus tests and prints the closing result
//##########################################################

`timescale 1ns/10ps

module axis_width_converter_tb
  import axis_pkg::*;
();

  localparam logic [15:0] lfsr_seed = 16'd18120;
  localparam logic [15:0] lfsr_taps = 16'hB400;
  localparam int send_timeout = 1000;
  localparam int drain_timeout = 4000;

  logic                 clk = 1'b0;
  logic                 reset;
  logic [in_width-1:0]  in_data;
  logic                 in_valid;
  logic                 in_last;
  logic                 in_ready;
  logic [out_width-1:0] out_data;
  logic                 out_valid;
  logic                 out_last;
  logic                 out_ready;

  int error_count;
  int packet_count;
  int pending_beats;

  logic [15:0] lfsr_state;
  logic        timed_out;
  logic        random_ready;
  int          gap_bits;
  int          packets_sent;
  int          errors_before;
  int          tests_run;
  int          assert_failures;

  always #4 clk = ~clk;

  axis_width_converter UUT (
    .clk(clk),
    .reset(reset),
    .in_data(in_data),
    .in_valid(in_valid),
    .in_last(in_last),
    .out_ready(out_ready),
    .in_ready(in_ready),
    .out_data(out_data),
    .out_valid(out_valid),
    .out_last(out_last)
  );

  axis_width_converter_checker checker_i (
    .clk(clk),
    .reset(reset),
    .in_data(in_data),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .in_last(in_last),
    .out_data(out_data),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_last(out_last),
    .error_count(error_count),
    .packet_count(packet_count),
    .pending_beats(pending_beats)
  );

  // one LFSR step per bit taken
  // the first bit ends up most significant
  function automatic int unsigned random_bits(input int count);
    int unsigned value;
    value = 0;
    for (int i = 0; i < count; i++) begin
      value = (value << 1) | lfsr_state[0];
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ lfsr_taps) : (lfsr_state >> 1);
    end
    return value;
  endfunction

  // every clock wait goes through here, so out_ready follows the same LFSR
  task automatic tick();
    @(posedge clk);
    if (random_ready) begin
      out_ready <= (random_bits(1) != 0);
    end else begin
      out_ready <= 1'b1;
    end
  endtask

  task automatic send_beat(input logic [in_width-1:0] data, input logic last);
    int waited;
    waited = 0;
    if (!timed_out) begin
      in_data <= data;
      in_valid <= 1'b1;
      in_last <= last;
      do begin
        tick();
        waited++;
      end while (!in_ready && waited < send_timeout);
      if (!in_ready) begin
        $display("timeout: input beat not accepted within %0d cycles", send_timeout);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic send_packet(input int length);
    int gap;
    for (int i = 0; i < length; i++) begin
      if (gap_bits > 0) begin
        gap = random_bits(gap_bits);
        if (gap > 0 && !timed_out) begin
          in_valid <= 1'b0;
          repeat (gap) tick();
        end
      end
      send_beat(in_width'(random_bits(in_width)), i == length - 1);
    end
    packets_sent++;
  endtask

  task automatic go_idle();
    in_valid <= 1'b0;
    in_last <= 1'b0;
  endtask

  task automatic wait_packets();
    int waited;
    waited = 0;
    while (!timed_out && packet_count < packets_sent && waited < drain_timeout) begin
      tick();
      waited++;
    end
    if (!timed_out && packet_count < packets_sent) begin
      $display("timeout: only %0d of %0d packets came out of the converter",
               packet_count, packets_sent);
      timed_out = 1'b1;
    end
  endtask

  task automatic end_test(input int number, input string name);
    $display("test %0d (%s) done with %0d errors", number, name, error_count - errors_before);
    errors_before = error_count;
    tests_run++;
  endtask

  initial begin
    reset = 1'b1;
    in_data = '0;
    in_valid = 1'b0;
    in_last = 1'b0;
    out_ready = 1'b1;
    lfsr_state = lfsr_seed;
    timed_out = 1'b0;
    random_ready = 1'b0;
    gap_bits = 0;
    packets_sent = 0;
    errors_before = 0;
    tests_run = 0;
    assert_failures = 0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    tick();

    send_packet(4);
    go_idle();
    wait_packets();
    end_test(1, "single full packet");

    send_packet(1);
    send_packet(5);
    send_packet(7);
    go_idle();
    wait_packets();
    end_test(2, "partial packets");

    random_ready = 1'b1;
    repeat (8) send_packet(random_bits(4) + 1);
    go_idle();
    wait_packets();
    random_ready = 1'b0;
    end_test(3, "random out_ready");

    gap_bits = 2;
    repeat (6) send_packet(random_bits(3) + 1);
    go_idle();
    wait_packets();
    gap_bits = 0;
    end_test(4, "random input gaps");

    // in_valid stays high from one packet into the next
    repeat (5) send_packet(random_bits(3) + 2);
    go_idle();
    wait_packets();
    end_test(5, "back-to-back packets");

    repeat (10) tick();
    assert_failures = UUT.assert_i.failures;
    if (!timed_out && pending_beats != 0) begin
      $display("%0d beats were left unmatched at the end of the run", pending_beats);
    end
    $display("tests: %0d, packets: %0d of %0d, errors: %0d, assertion failures: %0d",
             tests_run, packet_count, packets_sent, error_count, assert_failures);
    if (!timed_out && error_count == 0 && pending_beats == 0 && assert_failures == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
